// File: design/capture_pkg.sv
package capture_pkg;

   // ------------------------------------------------------------------------
   // widths and sizes
   // ------------------------------------------------------------------------
   localparam int AXNUM       = 24;   // antennae, one bit each per sample
   localparam int ADR_BITS    = 19;   // SDRAM word address
   localparam int TAG_BITS    = 8;    // sequence tag in the top byte
   localparam int BUF_DEPTH   = 16;   // FIFO words
   localparam int BUF_ABITS   = 4;    // FIFO pointer width
   localparam int CAPTURE_LEN = 64;   // strobes offered per capture

   // wide enough to hold CAPTURE_LEN
   localparam int CNT_BITS    = $clog2(CAPTURE_LEN) + 1;

   // ------------------------------------------------------------------------
   // vector types
   // ------------------------------------------------------------------------
   typedef logic [AXNUM-1:0]          sample_t;
   typedef logic [TAG_BITS+AXNUM-1:0] word_t;   // tag above sample, 32 bits
   typedef logic [ADR_BITS-1:0]       adr_t;
   typedef logic [TAG_BITS-1:0]       tag_t;

   // capture sequencer states
   typedef enum logic [2:0] {
      ST_IDLE  = 3'd0,   // waiting for a start
      ST_FILL  = 3'd1,   // sample window open
      ST_DRAIN = 3'd2,   // window closed, flushing to SDRAM
      ST_DONE  = 3'd3    // waiting for the host acknowledge
   } cap_state_t;

endpackage

// File: design/sample_buffer.sv
`timescale 1ns/1ps

module sample_buffer (
   input  logic                 clock_x,
   input  logic                 rst_n_i,
   input  logic                 clear_i,       // start of a new capture
   input  logic                 wr_en_i,       // offered strobe inside the window
   input  capture_pkg::sample_t sample_i,
   output capture_pkg::word_t   word_o,
   output logic                 word_valid_o,
   input  logic                 word_ready_i,
   output logic                 empty_o,
   output logic                 overflow_o     // sticky until the next clear
);
   import capture_pkg::*;

   word_t                mem [BUF_DEPTH];
   logic [BUF_ABITS-1:0] wr_ptr_q;
   logic [BUF_ABITS-1:0] rd_ptr_q;
   logic [BUF_ABITS:0]   count_q;         // one extra bit to tell full from empty
   tag_t                 tag_q;
   logic                 full;
   logic                 push;
   logic                 pop;

   // ------------------------------------------------------------------------
   // status and handshake
   // ------------------------------------------------------------------------
   assign full         = (count_q == (BUF_ABITS+1)'(BUF_DEPTH));
   assign empty_o      = (count_q == '0);
   assign word_valid_o = !empty_o;
   assign word_o       = mem[rd_ptr_q];       // head of queue, async read

   assign push = wr_en_i && !full;            // a full buffer drops the sample
   assign pop  = word_valid_o && word_ready_i;

   // ------------------------------------------------------------------------
   // storage, no reset on the array
   // ------------------------------------------------------------------------
   always_ff @(posedge clock_x) begin
      if (push) begin
         mem[wr_ptr_q] <= {tag_q, sample_i};   // tag sits above the sample
      end
   end

   // ------------------------------------------------------------------------
   // pointers, count, tag and overflow flag
   // ------------------------------------------------------------------------
   always_ff @(posedge clock_x) begin
      if (!rst_n_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         tag_q      <= '0;
         overflow_o <= 1'b0;
      end else if (clear_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         tag_q      <= '0;
         overflow_o <= 1'b0;
      end else begin
         // every offered strobe takes a tag, kept or not,
         // so a dropped sample leaves a gap downstream
         if (wr_en_i) begin
            tag_q <= tag_q + 1'b1;
         end
         if (wr_en_i && full) begin
            overflow_o <= 1'b1;
         end
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;      // wraps at BUF_DEPTH
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;       // both or neither
         endcase
      end
   end

endmodule

// File: design/capture_sequencer.sv
`timescale 1ns/1ps

module capture_sequencer (
   input  logic                    clock_x,
   input  logic                    rst_n_i,
   input  logic                    capture_i,    // start pulse
   input  logic                    request_i,    // host acknowledge
   input  logic                    strobe_i,     // raw sample strobe
   output logic                    wr_en_o,      // strobe gated by the window
   output logic                    clear_o,      // one cycle on a start
   output capture_pkg::adr_t       adr_o,
   output logic                    adr_valid_o,
   input  logic                    adr_ready_i,
   input  logic                    buf_empty_i,
   input  logic                    cmd_idle_i,   // issuer register empty
   output capture_pkg::cap_state_t state_o
);
   import capture_pkg::*;

   cap_state_t          state_q;
   cap_state_t          state_d;
   logic [CNT_BITS-1:0] strobe_cnt_q;   // strobes offered so far
   adr_t                adr_q;
   logic                start;
   logic                last_strobe;
   logic                adr_xfer;

   // ------------------------------------------------------------------------
   // window and handshake decode
   // ------------------------------------------------------------------------
   assign start       = capture_i && (state_q == ST_IDLE);   // ignored elsewhere
   assign clear_o     = start;
   assign wr_en_o     = strobe_i && (state_q == ST_FILL);
   assign last_strobe = wr_en_o && (strobe_cnt_q == CNT_BITS'(CAPTURE_LEN - 1));

   // addresses on offer while words may still arrive
   assign adr_valid_o = (state_q == ST_FILL) || (state_q == ST_DRAIN);
   assign adr_o       = adr_q;
   assign adr_xfer    = adr_valid_o && adr_ready_i;
   assign state_o     = state_q;

   // ------------------------------------------------------------------------
   // next state
   // ------------------------------------------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (start) begin
               state_d = ST_FILL;
            end
         end
         ST_FILL: begin
            if (last_strobe) begin
               state_d = ST_DRAIN;              // window closes on the last strobe
            end
         end
         ST_DRAIN: begin
            if (buf_empty_i && cmd_idle_i) begin
               state_d = ST_DONE;               // nothing left in flight
            end
         end
         ST_DONE: begin
            if (request_i) begin
               state_d = ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;           // unused encodings
      endcase
   end

   // ------------------------------------------------------------------------
   // state, strobe count and address counter
   // ------------------------------------------------------------------------
   always_ff @(posedge clock_x) begin
      if (!rst_n_i) begin
         state_q      <= ST_IDLE;
         strobe_cnt_q <= '0;
         adr_q        <= '0;
      end else begin
         state_q <= state_d;
         if (start) begin
            strobe_cnt_q <= '0;                 // every capture begins at 0
            adr_q        <= '0;
         end else begin
            if (wr_en_o) begin
               strobe_cnt_q <= strobe_cnt_q + 1'b1;
            end
            if (adr_xfer) begin
               adr_q <= adr_q + 1'b1;           // one word per address
            end
         end
      end
   end

endmodule

// File: design/mcb_command_issuer.sv
`timescale 1ns/1ps

module mcb_command_issuer (
   input  logic               clock_x,
   input  logic               rst_n_i,
   input  capture_pkg::word_t word_i,
   input  logic               word_valid_i,
   output logic               word_ready_o,
   input  capture_pkg::adr_t  adr_i,
   input  logic               adr_valid_i,
   output logic               adr_ready_o,
   output logic               mcb_ce_o,      // command valid
   input  logic               mcb_rdy_i,     // controller accepts
   output capture_pkg::adr_t  mcb_adr_o,
   output capture_pkg::word_t mcb_dat_o,
   output logic               cmd_idle_o
);
   import capture_pkg::*;

   adr_t  adr_q;
   word_t dat_q;
   logic  cmd_valid_q;
   logic  can_load;     // register empty or leaving this cycle
   logic  load;

   // ------------------------------------------------------------------------
   // join the word and address streams
   // ------------------------------------------------------------------------
   assign can_load = !cmd_valid_q || mcb_rdy_i;
   assign load     = word_valid_i && adr_valid_i && can_load;

   // each side is taken only together with the other
   assign word_ready_o = adr_valid_i && can_load;
   assign adr_ready_o  = word_valid_i && can_load;

   assign mcb_ce_o   = cmd_valid_q;
   assign mcb_adr_o  = adr_q;
   assign mcb_dat_o  = dat_q;
   assign cmd_idle_o = !cmd_valid_q;

   // payload, held while stalled
   always_ff @(posedge clock_x) begin
      if (load) begin
         adr_q <= adr_i;
         dat_q <= word_i;
      end
   end

   // valid flag, refilled in the same cycle as an accept
   always_ff @(posedge clock_x) begin
      if (!rst_n_i) begin
         cmd_valid_q <= 1'b0;
      end else if (load) begin
         cmd_valid_q <= 1'b1;
      end else if (mcb_rdy_i) begin
         cmd_valid_q <= 1'b0;                   // accepted, nothing behind it
      end
   end

endmodule

// File: design/raw_capture.sv
`timescale 1ns/1ps

module raw_capture (
   input  logic                    clock_x,     // sample clock
   input  logic                    rst_n_i,
   input  logic                    capture_i,   // start, honored in ST_IDLE
   input  logic                    request_i,   // ack, honored in ST_DONE
   input  logic                    strobe_i,    // new sample
   input  capture_pkg::sample_t    signal_i,    // one bit per antenna
   output logic                    mcb_ce_o,
   input  logic                    mcb_rdy_i,
   output capture_pkg::adr_t       mcb_adr_o,
   output capture_pkg::word_t      mcb_dat_o,
   output logic                    overflow_o,
   output capture_pkg::cap_state_t state_o
);
   import capture_pkg::*;

   // ------------------------------------------------------------------------
   // internal wiring
   // ------------------------------------------------------------------------
   logic  wr_en;
   logic  clear;
   word_t word;
   logic  word_valid;
   logic  word_ready;
   adr_t  adr;
   logic  adr_valid;
   logic  adr_ready;
   logic  buf_empty;
   logic  cmd_idle;

   // tags samples and rides out memory stalls
   sample_buffer u_buffer (
      .clock_x      (clock_x),
      .rst_n_i      (rst_n_i),
      .clear_i      (clear),
      .wr_en_i      (wr_en),
      .sample_i     (signal_i),
      .word_o       (word),
      .word_valid_o (word_valid),
      .word_ready_i (word_ready),
      .empty_o      (buf_empty),
      .overflow_o   (overflow_o)
   );

   // capture window and addresses
   capture_sequencer u_sequencer (
      .clock_x     (clock_x),
      .rst_n_i     (rst_n_i),
      .capture_i   (capture_i),
      .request_i   (request_i),
      .strobe_i    (strobe_i),
      .wr_en_o     (wr_en),
      .clear_o     (clear),
      .adr_o       (adr),
      .adr_valid_o (adr_valid),
      .adr_ready_i (adr_ready),
      .buf_empty_i (buf_empty),
      .cmd_idle_i  (cmd_idle),
      .state_o     (state_o)
   );

   // word plus address into one MCB write
   mcb_command_issuer u_issuer (
      .clock_x      (clock_x),
      .rst_n_i      (rst_n_i),
      .word_i       (word),
      .word_valid_i (word_valid),
      .word_ready_o (word_ready),
      .adr_i        (adr),
      .adr_valid_i  (adr_valid),
      .adr_ready_o  (adr_ready),
      .mcb_ce_o     (mcb_ce_o),
      .mcb_rdy_i    (mcb_rdy_i),
      .mcb_adr_o    (mcb_adr_o),
      .mcb_dat_o    (mcb_dat_o),
      .cmd_idle_o   (cmd_idle)
   );

endmodule

// File: tests/raw_capture_chk.sv
`timescale 1ns/1ps

module raw_capture_chk (
   input logic                    clock_x,
   input logic                    rst_n_i,
   input logic                    mcb_ce_o,
   input logic                    mcb_rdy_i,
   input capture_pkg::adr_t       mcb_adr_o,
   input capture_pkg::word_t      mcb_dat_o,
   input logic                    overflow_o,
   input capture_pkg::cap_state_t state_o
);
   import capture_pkg::*;

   int fail_count = 0;   // summed into the testbench error total

   // command held while the controller stalls
   a_cmd_hold : assert property (@(posedge clock_x) disable iff (!rst_n_i)
      mcb_ce_o && !mcb_rdy_i |=> mcb_ce_o && $stable(mcb_adr_o) && $stable(mcb_dat_o))
      else begin
         fail_count++;
         $error("mcb command changed while stalled");
      end

   a_ce_known : assert property (@(posedge clock_x) disable iff (!rst_n_i)
      !$isunknown(mcb_ce_o))
      else begin
         fail_count++;
         $error("mcb_ce_o unknown after reset");
      end

   // flag set by a dropped strobe, which only happens inside the window
   a_ovf_fill : assert property (@(posedge clock_x) disable iff (!rst_n_i)
      $rose(overflow_o) |-> $past(state_o) == ST_FILL)
      else begin
         fail_count++;
         $error("overflow_o rose outside ST_FILL");
      end

endmodule

// File: tests/raw_capture_tb.sv
`timescale 1ns/1ps

module raw_capture_tb;
   import capture_pkg::*;

   // longest capture runs a few hundred cycles, six of them fit with room to spare
   localparam int MAX_CYCLES = 20000;

   logic       clock_x = 1'b0;
   logic       rst_n_i;
   logic       capture_i;
   logic       request_i;
   logic       strobe_i;
   logic       mcb_rdy_i;
   sample_t    signal_i;
   logic       mcb_ce_o;
   adr_t       mcb_adr_o;
   word_t      mcb_dat_o;
   logic       overflow_o;
   cap_state_t state_o;
   int         errors = 0;
   int         checks = 0;
   int         cycles = 0;
   bit         random_stall = 1'b0;   // new mcb_rdy_i every cycle
   adr_t       got_adr [$];           // accepted commands, in order
   word_t      got_dat [$];
   sample_t    sent [CAPTURE_LEN];    // sample sent under each tag

   raw_capture UUT (.*);

   bind raw_capture raw_capture_chk u_chk (.*);

   always #10 clock_x = ~clock_x;     // 20 ns period

   // run limit
   always @(posedge clock_x) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, a capture never finished", cycles);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // memory side, sampled mid-cycle
   always @(negedge clock_x) begin
      if (rst_n_i && mcb_ce_o && mcb_rdy_i) begin
         got_adr.push_back(mcb_adr_o);
         got_dat.push_back(mcb_dat_o);
      end
   end

   // ------------------------------------------------------------------------
   // compare tasks
   // ------------------------------------------------------------------------
   task automatic check_word(string name, word_t exp, word_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_adr(string name, adr_t exp, adr_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error %s: expected adr %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_state(string name, cap_state_t exp, cap_state_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error %s: expected %s, actual %s", name, exp.name(), act.name());
      end
   endtask

   task automatic check_flag(string name, logic exp, logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error %s: expected flag %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_count(string name, int exp, int act);
      checks++;
      if (act != exp) begin
         errors++;
         $display("Error %s: expected count %0d, actual %0d", name, exp, act);
      end
   endtask

   // ------------------------------------------------------------------------
   // stimulus helpers
   // ------------------------------------------------------------------------
   task automatic next_cycle();
      @(posedge clock_x);
      #2;                                   // drive point
      if (random_stall) begin
         mcb_rdy_i = 1'($urandom_range(1, 0));
      end
   endtask

   task automatic start_capture();
      got_adr.delete();
      got_dat.delete();
      capture_i = 1'b1;
      next_cycle();
      capture_i = 1'b0;
   endtask

   task automatic offer_sample(int k, int gap);
      sent[k]  = sample_t'($urandom());
      signal_i = sent[k];
      strobe_i = 1'b1;
      next_cycle();
      strobe_i = 1'b0;
      repeat (gap - 1) next_cycle();
   endtask

   task automatic finish_capture(string name);
      while (state_o !== ST_DONE) begin
         next_cycle();
      end
      request_i = 1'b1;
      next_cycle();
      request_i = 1'b0;
      check_state(name, ST_IDLE, state_o);
   endtask

   // command k carries address k, tag k and sample k
   task automatic check_in_order(string name);
      check_count(name, CAPTURE_LEN, got_adr.size());
      for (int k = 0; k < got_adr.size() && k < CAPTURE_LEN; k++) begin
         check_adr(name, adr_t'(k), got_adr[k]);
         check_word(name, {tag_t'(k), sent[k]}, got_dat[k]);
      end
   endtask

   task automatic run_capture(string name, int gap);
      start_capture();
      for (int k = 0; k < CAPTURE_LEN; k++) begin
         offer_sample(k, gap);
      end
      finish_capture(name);
      check_in_order(name);
   endtask

   // ------------------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------------------
   task automatic test_reset();
      check_flag("test_reset", 1'b0, mcb_ce_o);
      check_flag("test_reset", 1'b0, overflow_o);
      check_state("test_reset", ST_IDLE, state_o);
   endtask

   task automatic test_basic_capture();
      run_capture("test_basic_capture", 2);
   endtask

   task automatic test_backpressure();
      random_stall = 1'b1;
      run_capture("test_backpressure", 4);   // half-rate drain still keeps up
      random_stall = 1'b0;
      mcb_rdy_i    = 1'b1;
      check_flag("test_backpressure", 1'b0, overflow_o);
   endtask

   task automatic test_overflow();
      int   prev;
      int   missing;
      int   stall_drops;
      tag_t tag;
      prev        = -1;
      missing     = 0;
      // stall holds the FIFO plus the issuer register
      // first strobe after the release still finds the FIFO full
      stall_drops = 24 + 1 - (BUF_DEPTH + 1);
      mcb_rdy_i   = 1'b0;                   // port stalled from the start
      start_capture();
      for (int k = 0; k < 24; k++) begin
         offer_sample(k, 1);
      end
      mcb_rdy_i = 1'b1;
      for (int k = 24; k < CAPTURE_LEN; k++) begin
         offer_sample(k, 2);
      end
      finish_capture("test_overflow");
      check_flag("test_overflow", 1'b1, overflow_o);
      foreach (got_dat[i]) begin
         tag = got_dat[i][AXNUM +: TAG_BITS];
         check_adr("test_overflow", adr_t'(i), got_adr[i]);
         if (int'(tag) <= prev || int'(tag) >= CAPTURE_LEN) begin
            errors++;
            $display("test_overflow: tag %0d at command %0d is out of order or out of range",
                     tag, i);
         end else begin
            check_word("test_overflow", {tag, sent[tag]}, got_dat[i]);
            missing += int'(tag) - prev - 1; // gap left by dropped samples
            prev = int'(tag);
         end
      end
      missing += CAPTURE_LEN - 1 - prev;
      check_count("test_overflow", stall_drops, missing);
      check_count("test_overflow", CAPTURE_LEN, got_dat.size() + stall_drops);
   endtask

   task automatic test_restart();
      check_flag("test_restart", 1'b1, overflow_o);   // left over from overflow run
      run_capture("test_restart", 2);
      check_flag("test_restart", 1'b0, overflow_o);
   endtask

   task automatic test_ignored_controls();
      start_capture();
      for (int k = 0; k < 32; k++) begin
         offer_sample(k, 2);
      end
      request_i = 1'b1;                     // ack outside ST_DONE
      next_cycle();
      request_i = 1'b0;
      check_state("test_ignored_controls", ST_FILL, state_o);
      for (int k = 32; k < CAPTURE_LEN - 1; k++) begin
         offer_sample(k, 2);
      end
      mcb_rdy_i = 1'b0;                     // hold the drain open
      offer_sample(CAPTURE_LEN - 1, 1);
      check_state("test_ignored_controls", ST_DRAIN, state_o);
      capture_i = 1'b1;                     // start outside ST_IDLE
      next_cycle();
      capture_i = 1'b0;
      check_state("test_ignored_controls", ST_DRAIN, state_o);
      mcb_rdy_i = 1'b1;
      finish_capture("test_ignored_controls");
      check_in_order("test_ignored_controls");
   endtask

   initial begin
      void'($urandom(32'hbd3c));
      rst_n_i   = 1'b0;
      capture_i = 1'b0;
      request_i = 1'b0;
      strobe_i  = 1'b0;
      mcb_rdy_i = 1'b1;
      signal_i  = '0;
      repeat (5) @(posedge clock_x);
      #2;
      rst_n_i = 1'b1;
      next_cycle();
      test_reset();
      test_basic_capture();
      test_backpressure();
      test_overflow();
      test_restart();
      test_ignored_controls();
      errors += UUT.u_chk.fail_count;
      $display("%0d checks, %0d errors (%0d from assertions)", checks, errors,
               UUT.u_chk.fail_count);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: all.f
design/capture_pkg.sv
design/sample_buffer.sv
design/capture_sequencer.sv
design/mcb_command_issuer.sv
design/raw_capture.sv
tests/raw_capture_chk.sv
tests/raw_capture_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
LINTFLAGS = --lint-only -Wall --timing
TOP       = raw_capture_tb
FILELIST  = all.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
